//--- sifh_assertions.sv
`timescale 1ns/1ns

module sifh_assertions (
    input logic             clk,
    input logic             res,
    input logic             ready,
    input logic             done,
    input logic             inc_en,
    input logic             scan_en,
    input sifh_pkg::state_t state
);

    int fail_count = 0;
    logic [sifh_pkg::ADDR_W:0] low_count;  // Cycles with ready low

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            low_count <= '0;
        end else if (ready) begin
            low_count <= '0;
        end else begin
            low_count <= low_count + 1'b1;
        end
    end

    done_single_cycle: assert property (@(posedge clk) disable iff (!res)
        done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_count++;
        end

    // Increment port and scan port share the RAM write path
    inc_scan_exclusive: assert property (@(posedge clk) disable iff (!res)
        !(inc_en && scan_en))
        else begin
            $error("inc_en and scan_en high in the same cycle");
            fail_count++;
        end

    // Low for the whole clear sweep, or for drain plus scan
    ready_low_when_busy: assert property (@(posedge clk) disable iff (!res)
        $rose(ready) |-> low_count == (($past(state) == sifh_pkg::CLEAR) ?
            sifh_pkg::ADDR_NUM : sifh_pkg::DRAIN_NUM + sifh_pkg::ADDR_NUM))
        else begin
            $error("ready rose before CLEAR, DRAIN or FIND had finished");
            fail_count++;
        end

endmodule

bind sifh_top sifh_assertions u_assert (
    .clk     (clk),
    .res     (res),
    .ready   (ready),
    .done    (done),
    .inc_en  (inc_en),
    .scan_en (scan_en),
    .state   (u_seq.state)
);

//--- sifh_hist_ram.sv
`timescale 1ns/1ns

module sifh_hist_ram (
    input  logic                        clk,
    input  logic                        inc_en,
    input  logic [sifh_pkg::ADDR_W-1:0] inc_addr,
    input  logic                        clr_en,
    input  logic                        scan_en,
    input  logic [sifh_pkg::ADDR_W-1:0] scan_addr,
    output logic [sifh_pkg::CNT_W-1:0]  scan_data
);

    logic [sifh_pkg::CNT_W-1:0] mem [sifh_pkg::ADDR_NUM];

    logic [sifh_pkg::ADDR_W-1:0] rd_addr;
    logic [sifh_pkg::CNT_W-1:0]  rd_q;

    // Increment pipeline, read stage then write stage
    logic                        p_valid;
    logic [sifh_pkg::ADDR_W-1:0] p_addr;
    logic                        p_fwd;    // Read missed the write in the same cycle
    logic [sifh_pkg::CNT_W-1:0]  p_sum;
    logic [sifh_pkg::CNT_W-1:0]  last_sum;

    logic                        we;
    logic [sifh_pkg::ADDR_W-1:0] wr_addr;
    logic [sifh_pkg::CNT_W-1:0]  wr_data;

    assign rd_addr = scan_en ? scan_addr : inc_addr;

    assign p_sum = (p_fwd ? last_sum : rd_q) + 1'b1;

    // Scan and clear both write zero at the sweep address
    assign we      = p_valid || scan_en || clr_en;
    assign wr_addr = p_valid ? p_addr : scan_addr;
    assign wr_data = p_valid ? p_sum : '0;

    always_ff @(posedge clk) begin
        rd_q <= mem[rd_addr];  // Read-first
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        p_valid <= inc_en;
        p_addr  <= inc_addr;
        p_fwd   <= inc_en && p_valid && (inc_addr == p_addr);
        if (p_valid) begin
            last_sum <= p_sum;
        end
    end

    assign scan_data = rd_q;

endmodule

//--- sifh_peak_finder.sv
`timescale 1ns/1ns

module sifh_peak_finder (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          scan_valid,
    input  logic [sifh_pkg::CNT_W-1:0]    scan_data,
    input  logic                          scan_first,
    input  logic                          scan_last,
    output logic [sifh_pkg::RESULT_W-1:0] result,
    output logic                          done
);

    logic [sifh_pkg::NB-1:0]    bin_count;
    logic [sifh_pkg::NB-1:0]    cur_bin;
    logic [sifh_pkg::NB-1:0]    best_bin;
    logic [sifh_pkg::NB-1:0]    win_bin;
    logic [sifh_pkg::CNT_W-1:0] best_cnt;
    logic [sifh_pkg::PIX_W-1:0] pix_count;
    logic                       take;
    logic                       pix_last;

    assign cur_bin = scan_first ? '0 : bin_count;

    // Strictly greater, so the lowest bin keeps a tie
    assign take    = scan_first || (scan_data > best_cnt);
    assign win_bin = take ? cur_bin : best_bin;

    assign pix_last = (pix_count == sifh_pkg::PIXEL_NUM - 1);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bin_count <= '0;
            pix_count <= '0;
            result    <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (scan_valid) begin
                bin_count <= cur_bin + 1'b1;
                if (scan_last) begin
                    result[pix_count*sifh_pkg::NB +: sifh_pkg::NB] <= win_bin;
                    pix_count <= pix_last ? '0 : pix_count + 1'b1;
                    done      <= pix_last;  // Whole frame scanned
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scan_valid && take) begin
            best_cnt <= scan_data;
            best_bin <= cur_bin;
        end
    end

endmodule

//--- sifh_pkg.sv
package sifh_pkg;

    localparam int NP        = 12;  // Timestamp width
    localparam int NB        = 4;   // Bin index bits, top of timestamp
    localparam int BIN_NUM   = 16;
    localparam int PIXEL_NUM = 4;
    localparam int DATA_NUM  = 2;   // Samples per pixel per pass
    localparam int ACQ_NUM   = 8;   // Passes per frame
    localparam int CNT_W     = 6;   // Fits DATA_NUM * ACQ_NUM

    localparam int ADDR_NUM  = PIXEL_NUM * BIN_NUM;
    localparam int ADDR_W    = $clog2(ADDR_NUM);
    localparam int RESULT_W  = NB * PIXEL_NUM;

    // Counter widths
    localparam int IN_W      = $clog2(DATA_NUM);
    localparam int PIX_W     = $clog2(PIXEL_NUM);
    localparam int ACQ_W     = $clog2(ACQ_NUM);

    localparam int DRAIN_NUM = 2;   // Increment pipeline depth
    localparam int DRAIN_W   = $clog2(DRAIN_NUM);

    typedef enum logic [2:0] {
        CLEAR = 3'd0,
        IDLE  = 3'd1,
        BUILD = 3'd2,
        DRAIN = 3'd3,
        FIND  = 3'd4
    } state_t;

endpackage

//--- sifh_sequencer.sv
`timescale 1ns/1ns

module sifh_sequencer (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       wr_en,
    input  logic [sifh_pkg::NP-1:0]    data,
    output logic                       ready,
    output logic                       inc_en,
    output logic [sifh_pkg::ADDR_W-1:0] inc_addr,
    output logic                       clr_en,
    output logic                       scan_en,
    output logic [sifh_pkg::ADDR_W-1:0] scan_addr,
    output logic                       scan_first,
    output logic                       scan_last
);

    sifh_pkg::state_t state, next_state;

    logic [sifh_pkg::IN_W-1:0]    input_count;
    logic [sifh_pkg::PIX_W-1:0]   pixel_count;
    logic [sifh_pkg::ACQ_W-1:0]   acq_count;
    logic [sifh_pkg::ADDR_W-1:0]  addr_count;  // Shared by clear and scan sweeps
    logic [sifh_pkg::DRAIN_W-1:0] drain_count;

    logic accept;
    logic in_last, pix_last, frame_last;
    logic sweep_last;

    assign ready   = (state == sifh_pkg::IDLE) || (state == sifh_pkg::BUILD);
    assign clr_en  = (state == sifh_pkg::CLEAR);
    assign scan_en = (state == sifh_pkg::FIND);
    assign scan_addr = addr_count;

    assign accept     = wr_en && ready;
    assign in_last    = (input_count == sifh_pkg::DATA_NUM - 1);
    assign pix_last   = (pixel_count == sifh_pkg::PIXEL_NUM - 1);
    assign frame_last = in_last && pix_last && (acq_count == sifh_pkg::ACQ_NUM - 1);
    assign sweep_last = (addr_count == sifh_pkg::ADDR_NUM - 1);

    always_comb begin
        next_state = state;
        case (state)
            sifh_pkg::CLEAR: if (sweep_last) next_state = sifh_pkg::IDLE;
            sifh_pkg::IDLE, sifh_pkg::BUILD: begin
                if (accept && frame_last) begin
                    next_state = sifh_pkg::DRAIN;
                end else if (accept) begin
                    next_state = sifh_pkg::BUILD;
                end
            end
            sifh_pkg::DRAIN: begin
                if (drain_count == sifh_pkg::DRAIN_NUM - 1) next_state = sifh_pkg::FIND;
            end
            sifh_pkg::FIND: if (sweep_last) next_state = sifh_pkg::IDLE;
            default: next_state = sifh_pkg::CLEAR;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= sifh_pkg::CLEAR;
            input_count <= '0;
            pixel_count <= '0;
            acq_count   <= '0;
            addr_count  <= '0;
            drain_count <= '0;
            inc_en      <= 1'b0;
            scan_first  <= 1'b0;
            scan_last   <= 1'b0;
        end else begin
            state  <= next_state;
            inc_en <= accept;

            // Sample order: input, then pixel, then pass
            if (accept) begin
                if (in_last) begin
                    input_count <= '0;
                    if (pix_last) begin
                        pixel_count <= '0;
                        acq_count <= frame_last ? '0 : acq_count + 1'b1;
                    end else begin
                        pixel_count <= pixel_count + 1'b1;
                    end
                end else begin
                    input_count <= input_count + 1'b1;
                end
            end

            if (clr_en || scan_en) begin
                addr_count <= sweep_last ? '0 : addr_count + 1'b1;
            end

            drain_count <= (state == sifh_pkg::DRAIN) ? drain_count + 1'b1 : '0;

            // Aligned with scan_data, one cycle behind the address
            scan_first <= scan_en && (addr_count[sifh_pkg::NB-1:0] == '0);
            scan_last  <= scan_en && (&addr_count[sifh_pkg::NB-1:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) inc_addr <= {pixel_count, data[sifh_pkg::NP-1 -: sifh_pkg::NB]};
    end

endmodule

//--- sifh_tb.sv
`timescale 1ns/1ns

module sifh_tb;

    typedef logic [sifh_pkg::NP-1:0] frame_t
        [sifh_pkg::DATA_NUM * sifh_pkg::PIXEL_NUM * sifh_pkg::ACQ_NUM];

    logic                          clk;
    logic                          res;
    logic                          wr_en;
    logic [sifh_pkg::NP-1:0]       data;
    logic                          ready;
    logic                          done;
    logic [sifh_pkg::RESULT_W-1:0] result;

    logic [15:0]                   lfsr;
    logic [sifh_pkg::RESULT_W-1:0] exp_result;
    int errors;
    int done_count;
    int tests_run;
    int tests_failed;

    sifh_top UUT (
        .clk    (clk),
        .res    (res),
        .wr_en  (wr_en),
        .data   (data),
        .ready  (ready),
        .done   (done),
        .result (result)
    );

    always #4 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    // Expected peak bins, rebuilt from the sample order
    function automatic logic [sifh_pkg::RESULT_W-1:0] peak_bins(input frame_t f);
        int hist [sifh_pkg::PIXEL_NUM][sifh_pkg::BIN_NUM];
        int pix;
        int best;
        logic [sifh_pkg::RESULT_W-1:0] r;
        r = '0;
        foreach (hist[p, b]) hist[p][b] = 0;
        for (int i = 0; i < $size(f); i++) begin
            pix = (i / sifh_pkg::DATA_NUM) % sifh_pkg::PIXEL_NUM;
            hist[pix][f[i][sifh_pkg::NP-1 -: sifh_pkg::NB]]++;
        end
        for (int p = 0; p < sifh_pkg::PIXEL_NUM; p++) begin
            best = 0;
            for (int b = 1; b < sifh_pkg::BIN_NUM; b++) begin
                if (hist[p][b] > hist[p][best]) best = b;  // Lower bin keeps a tie
            end
            r[p*sifh_pkg::NB +: sifh_pkg::NB] = best[sifh_pkg::NB-1:0];
        end
        return r;
    endfunction

    task automatic check_result(input logic [sifh_pkg::RESULT_W-1:0] act,
                                input logic [sifh_pkg::RESULT_W-1:0] expd);
        for (int p = 0; p < sifh_pkg::PIXEL_NUM; p++) begin
            if (act[p*sifh_pkg::NB +: sifh_pkg::NB] !== expd[p*sifh_pkg::NB +: sifh_pkg::NB]) begin
                $display("ERROR %0t result[pixel %0d] expected %0d got %0d", $time, p,
                         expd[p*sifh_pkg::NB +: sifh_pkg::NB],
                         act[p*sifh_pkg::NB +: sifh_pkg::NB]);
                errors++;
            end
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic expd);
        if (act !== expd) begin
            $display("ERROR %0t %s expected %b got %b", $time, name, expd, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int act, input int expd);
        if (act != expd) begin
            $display("ERROR %0t %s expected %0d got %0d", $time, name, expd, act);
            errors++;
        end
    endtask

    // Compares every frame result as done pulses
    always @(negedge clk) begin
        if (res && done) begin
            check_result(result, exp_result);
            done_count++;
        end
    end

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (!ready && n < limit) begin
            @(negedge clk);
            check_flag("done", done, 1'b0);
            n++;
        end
        if (!ready) begin
            $display("Timeout: ready did not rise within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic wait_done(input int start, input int limit);
        int n;
        n = 0;
        while (done_count == start && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (done_count == start) begin
            $display("Timeout: done did not pulse within %0d cycles after the frame", limit);
            errors++;
        end
    endtask

    task automatic send_frame(input frame_t f, input bit gaps, input int junk);
        logic [15:0] v;
        for (int i = 0; i < $size(f); i++) begin
            if (gaps) begin
                take_bits(2, v);
                if (v[1:0] == 2'b11) begin  // About one gap in four
                    @(posedge clk);
                    wr_en <= 1'b0;
                end
            end
            @(posedge clk);
            wr_en <= 1'b1;
            data  <= f[i];
        end
        // Strobes while the frame drains and is scanned
        repeat (junk) begin
            @(posedge clk);
            take_bits(sifh_pkg::NP, v);
            wr_en <= 1'b1;
            data  <= v[sifh_pkg::NP-1:0];
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic run_frame(input frame_t f, input bit gaps, input int junk);
        int start;
        exp_result = peak_bins(f);
        wait_ready(200);
        start = done_count;
        send_frame(f, gaps, junk);
        wait_done(start, 200);
        repeat (8) @(negedge clk);
        check_count("done pulses per frame", done_count - start, 1);
    endtask

    task automatic random_frame(output frame_t f);
        logic [15:0] v;
        foreach (f[i]) begin
            take_bits(sifh_pkg::NP, v);
            f[i] = v[sifh_pkg::NP-1:0];
        end
    endtask

    task automatic finish_test(input string name, input int err_mark);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
    endtask

    initial begin
        frame_t f;
        logic [15:0] v;
        int err_mark;
        int pix;
        int tmp;

        clk = 1'b0;
        res = 1'b0;
        wr_en = 1'b0;
        data = '0;
        lfsr = 16'd22;
        errors = 0;
        done_count = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        res <= 1'b1;

        err_mark = errors;
        @(negedge clk);
        check_flag("ready", ready, 1'b0);
        check_flag("done", done, 1'b0);
        wait_ready(sifh_pkg::ADDR_NUM + 16);
        finish_test("1 reset and clear sweep", err_mark);

        err_mark = errors;
        random_frame(f);
        run_frame(f, 1'b1, 0);
        finish_test("2 random frame with gaps", err_mark);

        err_mark = errors;
        random_frame(f);
        run_frame(f, 1'b0, 0);
        finish_test("5 second random frame", err_mark);

        err_mark = errors;
        foreach (f[i]) begin
            take_bits(sifh_pkg::NP, v);
            pix = (i / sifh_pkg::DATA_NUM) % sifh_pkg::PIXEL_NUM;
            tmp = 3 + 5 * pix;
            f[i] = v[sifh_pkg::NP-1:0];
            f[i][sifh_pkg::NP-1 -: sifh_pkg::NB] = tmp[sifh_pkg::NB-1:0];
        end
        run_frame(f, 1'b0, 0);
        finish_test("3 one bin per pixel back to back", err_mark);

        err_mark = errors;
        random_frame(f);
        foreach (f[i]) begin
            pix = (i / sifh_pkg::DATA_NUM) % sifh_pkg::PIXEL_NUM;
            if (pix == 2) begin
                tmp = (i / (sifh_pkg::DATA_NUM * sifh_pkg::PIXEL_NUM)) * sifh_pkg::DATA_NUM
                      + i % sifh_pkg::DATA_NUM;
                tmp = sifh_pkg::BIN_NUM - 1 - tmp;  // Falling bins, all counts equal
                f[i][sifh_pkg::NP-1 -: sifh_pkg::NB] = tmp[sifh_pkg::NB-1:0];
            end
        end
        run_frame(f, 1'b0, 0);
        finish_test("4 tie on pixel 2", err_mark);

        err_mark = errors;
        random_frame(f);
        run_frame(f, 1'b0, 20);
        random_frame(f);
        run_frame(f, 1'b1, 0);
        finish_test("6 strobes during drain and scan", err_mark);

        errors = errors + UUT.u_assert.fail_count;
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sifh_top.sv
`timescale 1ns/1ns

module sifh_top (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          wr_en,
    input  logic [sifh_pkg::NP-1:0]       data,
    output logic                          ready,
    output logic                          done,
    output logic [sifh_pkg::RESULT_W-1:0] result
);

    logic                        inc_en;
    logic [sifh_pkg::ADDR_W-1:0] inc_addr;
    logic                        clr_en;
    logic                        scan_en;
    logic [sifh_pkg::ADDR_W-1:0] scan_addr;
    logic                        scan_first;
    logic                        scan_last;
    logic [sifh_pkg::CNT_W-1:0]  scan_data;
    logic                        scan_valid;

    sifh_sequencer u_seq (
        .clk        (clk),
        .res        (res),
        .wr_en      (wr_en),
        .data       (data),
        .ready      (ready),
        .inc_en     (inc_en),
        .inc_addr   (inc_addr),
        .clr_en     (clr_en),
        .scan_en    (scan_en),
        .scan_addr  (scan_addr),
        .scan_first (scan_first),
        .scan_last  (scan_last)
    );

    sifh_hist_ram u_ram (
        .clk       (clk),
        .inc_en    (inc_en),
        .inc_addr  (inc_addr),
        .clr_en    (clr_en),
        .scan_en   (scan_en),
        .scan_addr (scan_addr),
        .scan_data (scan_data)
    );

    // RAM read latency
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scan_valid <= 1'b0;
        end else begin
            scan_valid <= scan_en;
        end
    end

    sifh_peak_finder u_peak (
        .clk        (clk),
        .res        (res),
        .scan_valid (scan_valid),
        .scan_data  (scan_data),
        .scan_first (scan_first),
        .scan_last  (scan_last),
        .result     (result),
        .done       (done)
    );

endmodule

//--- verilog.f
sifh_pkg.sv
sifh_sequencer.sv
sifh_hist_ram.sv
sifh_peak_finder.sv
sifh_top.sv
sifh_assertions.sv
sifh_tb.sv
